/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f src.f --top-module tb_cpl_rx -o sim_cpl_rx
	./obj_dir/sim_cpl_rx | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* design/commit_track.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rx_cfg.svh"

module commit_track import rx_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    rd_issue_if.sink issue,
    cpl_beat_if.mon  beats,
    input  logic     cpl_end,
    input  tag_t     end_tag,
    input  qw_len_t  end_qw,
    output buf_ptr_t committed_prod,
    output req_cnt_t done_count,
    output logic     cpl_rcved,
    output dw_len_t  cpl_dws
);

    localparam int NTAG = 1 << `RX_TAG_W;

    qw_len_t  rq_len  [NTAG];
    qw_len_t  rcv_len [NTAG];
    buf_ptr_t rq_base [NTAG];
    tag_t     order   [NTAG];   // tags in issue order
    req_cnt_t wr_cnt;
    tag_t     head;
    logic     head_done;
    logic     rcv_pend;
    dw_len_t  cur_dws;
    dw_len_t  pend_dws;

    assign head      = order[done_count[`RX_TAG_W-1:0]];
    assign head_done = (wr_cnt != done_count) && (rcv_len[head] == rq_len[head]);

    always_ff @(posedge clk) begin
        if (issue.issued) begin
            rq_len[issue.tag]               <= issue.len_qw;
            rq_base[issue.tag]              <= issue.base;
            order[wr_cnt[`RX_TAG_W-1:0]]    <= issue.tag;
        end
        if (cpl_end) begin
            rcv_len[end_tag] <= rcv_len[end_tag] + end_qw;
        end
        if (issue.issued) begin
            rcv_len[issue.tag] <= '0;
        end
        if (beats.hdr_valid) begin
            cur_dws <= beats.len_dw;
        end
        pend_dws <= cur_dws;
        cpl_dws  <= pend_dws;
    end

    //////////////////////////////
    // in order commit
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_cnt         <= '0;
            done_count     <= '0;
            committed_prod <= '0;
            rcv_pend       <= 1'b0;
            cpl_rcved      <= 1'b0;
        end else begin
            rcv_pend  <= cpl_end;
            cpl_rcved <= rcv_pend;
            if (issue.issued) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (head_done) begin
                committed_prod <= rq_base[head] + buf_ptr_t'(rq_len[head]);
                done_count     <= done_count + 1'b1;   // head retired
            end
        end
    end

endmodule

`default_nettype wire

/* design/cpl_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rx_cfg.svh"

module cpl_decode import rx_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [`RX_DW-1:0] rx_data,
    input  logic              rx_sof,
    input  logic              rx_eof,
    input  logic              rx_valid,
    cpl_beat_if.src           beats
);

    dec_state_e state;
    logic       hdr_ok;
    logic       tag_ok;

    // beat 1 holds DW0 high and DW1 low, beat 2 holds DW2 high
    assign hdr_ok = (rx_data[62:56] == `RX_CPLD_CODE) && (rx_data[15:13] == `RX_SC);
    assign tag_ok = rx_data[47:40+`RX_TAG_W] == `RX_TAG_BASE;

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= DEC_IDLE;
            beats.hdr_valid  <= 1'b0;
            beats.beat_valid <= 1'b0;
        end else begin
            beats.hdr_valid  <= 1'b0;
            beats.beat_valid <= 1'b0;
            if (rx_valid && rx_sof) begin
                beats.len_dw <= rx_data[41:32];
                state        <= hdr_ok ? DEC_HDR2 : DEC_IDLE;
            end else if (rx_valid) begin
                case (state)
                    DEC_HDR2: begin
                        beats.tag <= rx_data[40 +: `RX_TAG_W];
                        if (tag_ok) begin
                            beats.hdr_valid  <= 1'b1;
                            beats.beat_valid <= 1'b1;   // first payload DW in low half
                            state            <= rx_eof ? DEC_IDLE : DEC_DATA;
                        end else begin
                            state <= DEC_IDLE;          // foreign tag, drop frame
                        end
                    end
                    DEC_DATA: begin
                        beats.beat_valid <= 1'b1;
                        if (rx_eof) begin
                            state <= DEC_IDLE;
                        end
                    end
                    default: state <= DEC_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid) begin
            beats.data <= rx_data;
            beats.last <= rx_eof;
        end
    end

endmodule

`default_nettype wire

/* design/cpl_realign.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rx_cfg.svh"

module cpl_realign import rx_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    rd_issue_if.sink          issue,
    cpl_beat_if.sink          beats,
    output logic              wr_en,
    output buf_addr_t         wr_addr,
    output logic [`RX_DW-1:0] wr_data,
    output logic              cpl_end,
    output tag_t              end_tag,
    output qw_len_t           end_qw
);

    localparam int NTAG = 1 << `RX_TAG_W;

    // per tag write state
    buf_addr_t         waddr  [NTAG];
    logic [31:0]       sav_dw [NTAG];
    logic [NTAG-1:0]   sav_en;

    align_e            mode;
    align_e            cur_mode;
    buf_addr_t         addr;
    buf_addr_t         cur_addr;
    logic [31:0]       carry;      // low DW of the previous beat
    logic [31:0]       hi;
    logic [31:0]       lo;
    logic [31:0]       keep_dw;
    logic              keep;
    logic              do_wr;
    logic              end_pend;
    logic [`RX_DW-1:0] qw;

    function automatic logic [31:0] swap32(input logic [31:0] d);
        return {d[7:0], d[15:8], d[23:16], d[31:24]};
    endfunction

    // later beats carry the earlier DW in the high half
    assign hi = beats.data[`RX_DW-1:32];
    assign lo = beats.data[31:0];

    //////////////////////////////
    // packing case per beat
    //////////////////////////////
    always_comb begin
        mode = cur_mode;
        addr = cur_addr;
        if (beats.hdr_valid) begin
            mode = align_e'({sav_en[beats.tag], beats.len_dw[0]});
            addr = waddr[beats.tag];
        end
        do_wr   = 1'b0;
        keep    = 1'b0;
        keep_dw = lo;
        qw      = {swap32(hi), swap32(carry)};
        case (mode)
            ALIGN_EE: do_wr = !beats.hdr_valid;   // first DW waits in carry
            ALIGN_EO: begin
                do_wr = !beats.hdr_valid;
                keep  = beats.last;               // odd DW left over
            end
            default: begin                        // saved DW fills the first low half
                do_wr   = !(mode == ALIGN_OO && beats.last);
                keep    = (mode == ALIGN_OO) && beats.last;
                keep_dw = hi;
                if (beats.hdr_valid) begin
                    qw = {swap32(lo), swap32(sav_dw[beats.tag])};
                end else begin
                    qw = {swap32(lo), swap32(hi)};
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en    <= 1'b0;
            end_pend <= 1'b0;
            cpl_end  <= 1'b0;
            sav_en   <= '0;
        end else begin
            wr_en    <= beats.beat_valid && do_wr;
            end_pend <= beats.beat_valid && beats.last;
            cpl_end  <= end_pend;                 // one cycle after the last write
            if (beats.beat_valid && beats.last) begin
                sav_en[beats.tag] <= keep;
            end
            if (issue.issued) begin
                sav_en[issue.tag] <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // write path and tag update
    //////////////////////////////
    always_ff @(posedge clk) begin
        wr_addr <= addr;
        wr_data <= qw;
        if (beats.beat_valid) begin
            carry    <= lo;
            cur_mode <= mode;
            cur_addr <= addr + buf_addr_t'(do_wr);
            if (beats.last) begin
                waddr[beats.tag]  <= addr + buf_addr_t'(do_wr);
                sav_dw[beats.tag] <= keep_dw;
                end_tag           <= beats.tag;
                // mode[1] is the saved flag at start
                end_qw <= qw_len_t'((11'(beats.len_dw) + 11'(mode[1])) >> 1);
            end
        end
        if (issue.issued) begin
            waddr[issue.tag] <= issue.base[`RX_BUF_AW-1:0];
        end
    end

endmodule

`default_nettype wire

/* design/cpl_rx_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rx_cfg.svh"

module cpl_rx_top import rx_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [63:0]       desc_addr,
    input  logic [31:0]       desc_len,
    input  logic              desc_valid,
    output logic              desc_done,
    input  logic [2:0]        max_rd_req,
    input  logic [`RX_DW-1:0] rx_data,
    input  logic              rx_sof,
    input  logic              rx_eof,
    input  logic              rx_valid,
    output logic              rd,
    output logic [63:0]       rd_addr,
    output qw_len_t           rd_qw,
    input  logic              rd_ack,
    input  tag_t              rd_tag,
    output logic              wr_en,
    output buf_addr_t         wr_addr,
    output logic [`RX_DW-1:0] wr_data,
    output buf_ptr_t          committed_prod,
    input  buf_ptr_t          committed_cons,
    output logic              cpl_rcved,
    output dw_len_t           cpl_dws
);

    cpl_beat_if beats ();
    rd_issue_if issue ();

    logic     cpl_end;
    tag_t     end_tag;
    qw_len_t  end_qw;
    req_cnt_t done_count;

    rd_request i_rd_request (
        .clk            (clk),
        .rst            (rst),
        .desc_addr      (desc_addr),
        .desc_len       (desc_len),
        .desc_valid     (desc_valid),
        .desc_done      (desc_done),
        .max_rd_req     (max_rd_req),
        .committed_cons (committed_cons),
        .done_count     (done_count),
        .rd             (rd),
        .rd_addr        (rd_addr),
        .rd_qw          (rd_qw),
        .rd_ack         (rd_ack),
        .rd_tag         (rd_tag),
        .issue          (issue.src)
    );

    cpl_decode i_cpl_decode (
        .clk      (clk),
        .rst      (rst),
        .rx_data  (rx_data),
        .rx_sof   (rx_sof),
        .rx_eof   (rx_eof),
        .rx_valid (rx_valid),
        .beats    (beats.src)
    );

    cpl_realign i_cpl_realign (
        .clk     (clk),
        .rst     (rst),
        .issue   (issue.sink),
        .beats   (beats.sink),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .cpl_end (cpl_end),
        .end_tag (end_tag),
        .end_qw  (end_qw)
    );

    commit_track i_commit_track (
        .clk            (clk),
        .rst            (rst),
        .issue          (issue.sink),
        .beats          (beats.mon),
        .cpl_end        (cpl_end),
        .end_tag        (end_tag),
        .end_qw         (end_qw),
        .committed_prod (committed_prod),
        .done_count     (done_count),
        .cpl_rcved      (cpl_rcved),
        .cpl_dws        (cpl_dws)
    );

endmodule

`default_nettype wire

/* design/rd_request.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rx_cfg.svh"

module rd_request import rx_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [63:0] desc_addr,
    input  logic [31:0] desc_len,
    input  logic        desc_valid,
    output logic        desc_done,
    input  logic [2:0]  max_rd_req,
    input  buf_ptr_t    committed_cons,
    input  req_cnt_t    done_count,
    output logic        rd,
    output logic [63:0] rd_addr,
    output qw_len_t     rd_qw,
    input  logic        rd_ack,
    input  tag_t        rd_tag,
    rd_issue_if.src     issue
);

    rd_state_e   state;
    logic [2:0]  mx_reg;
    qw_len_t     cap;
    qw_len_t     sz;
    qw_len_t     req_sz;
    logic [63:0] host_addr;
    logic [31:0] left;         // QWs still to request
    buf_ptr_t    ptr;
    buf_ptr_t    occ;
    req_cnt_t    sent;
    req_cnt_t    os;
    logic        room_ok;
    logic        os_ok;

    assign sz  = (left > 32'(cap)) ? cap : qw_len_t'(left);
    assign occ = ptr - committed_cons;   // wrap bit keeps this right
    assign os  = sent - done_count;

    //////////////////////////////
    // size cap and limits
    //////////////////////////////
    always_ff @(posedge clk) begin
        mx_reg <= max_rd_req;
        if (mx_reg[2] || (&mx_reg[1:0])) begin
            cap <= 10'd128;
        end else if (mx_reg[1]) begin
            cap <= 10'd64;
        end else if (mx_reg[0]) begin
            cap <= 10'd32;
        end else begin
            cap <= 10'd16;
        end
        req_sz  <= sz;
        room_ok <= ({1'b0, occ} + 11'(sz)) <= 11'(1 << `RX_BUF_AW);
        os_ok   <= os < req_cnt_t'(1 << `RX_TAG_W);
    end

    //////////////////////////////
    // request FSM
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= RD_IDLE;
            rd           <= 1'b0;
            desc_done    <= 1'b0;
            issue.issued <= 1'b0;
            ptr          <= '0;
            sent         <= '0;
        end else begin
            desc_done    <= 1'b0;
            issue.issued <= 1'b0;
            case (state)
                RD_IDLE: begin
                    host_addr <= desc_addr;
                    left      <= desc_len;
                    if (desc_valid) begin
                        state <= RD_NEXT;
                    end
                end
                RD_NEXT: begin
                    if (left == '0) begin
                        desc_done <= 1'b1;   // last request went out
                        state     <= RD_IDLE;
                    end else begin
                        state <= RD_WAIT;
                    end
                end
                RD_WAIT: state <= RD_CHECK;   // let req_sz and room_ok settle
                RD_CHECK: begin
                    rd_addr <= host_addr;
                    rd_qw   <= req_sz;
                    if (room_ok && os_ok) begin
                        rd    <= 1'b1;
                        state <= RD_ACK;
                    end
                end
                RD_ACK: begin
                    if (rd_ack) begin
                        rd           <= 1'b0;
                        issue.issued <= 1'b1;
                        issue.tag    <= rd_tag;
                        issue.base   <= ptr;
                        issue.len_qw <= rd_qw;
                        ptr          <= ptr + buf_ptr_t'(rd_qw);
                        host_addr    <= host_addr + 64'({rd_qw, 3'b000});
                        left         <= left - 32'(rd_qw);
                        sent         <= sent + 1'b1;
                        state        <= RD_NEXT;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/rx_cfg.svh */
`ifndef RX_CFG_SVH
`define RX_CFG_SVH

// receive buffer, in QW
`define RX_BUF_AW     9

// request tags, 8 outstanding
`define RX_TAG_W      3
`define RX_TAG_BASE   5'd0          // tag bits [7:RX_TAG_W]

// stream and buffer word
`define RX_DW         64

// completion header codes
`define RX_CPLD_CODE  7'b100_1010   // fmt/type, completion with data
`define RX_SC         3'b000        // successful completion

`endif

/* design/rx_ifs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rx_cfg.svh"

// decoded completion beats
interface cpl_beat_if import rx_pkg::*; ();
    logic              hdr_valid;   // comes with the first payload beat
    tag_t              tag;
    dw_len_t           len_dw;
    logic              beat_valid;
    logic [`RX_DW-1:0] data;
    logic              last;

    modport src (output hdr_valid, tag, len_dw, beat_valid, data, last);
    modport sink (input hdr_valid, tag, len_dw, beat_valid, data, last);
    modport mon (input hdr_valid, len_dw);
endinterface

// one granted read request
interface rd_issue_if import rx_pkg::*; ();
    logic     issued;
    tag_t     tag;
    buf_ptr_t base;      // buffer pointer of the first QW
    qw_len_t  len_qw;

    modport src (output issued, tag, base, len_qw);
    modport sink (input issued, tag, base, len_qw);
endinterface

`default_nettype wire

/* design/rx_pkg.sv */
`default_nettype none
`include "rx_cfg.svh"

package rx_pkg;

    typedef logic [`RX_BUF_AW:0]   buf_ptr_t;   // wrap bit on top
    typedef logic [`RX_BUF_AW-1:0] buf_addr_t;
    typedef logic [`RX_TAG_W-1:0]  tag_t;
    typedef logic [`RX_TAG_W:0]    req_cnt_t;   // reaches 2**RX_TAG_W
    typedef logic [9:0]            qw_len_t;
    typedef logic [9:0]            dw_len_t;

    // packing case, {saved dw at start, odd length}
    typedef enum logic [1:0] {
        ALIGN_EE = 2'b00,
        ALIGN_EO = 2'b01,
        ALIGN_OO = 2'b10,
        ALIGN_OE = 2'b11
    } align_e;

    typedef enum logic [2:0] {
        RD_IDLE,
        RD_NEXT,
        RD_WAIT,
        RD_CHECK,
        RD_ACK
    } rd_state_e;

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_HDR2,
        DEC_DATA
    } dec_state_e;

endpackage

`default_nettype wire

/* src.f */
+incdir+design
design/rx_pkg.sv
design/rx_ifs.sv
design/rd_request.sv
design/cpl_decode.sv
design/cpl_realign.sv
design/commit_track.sv
design/cpl_rx_top.sv
verif/tb_clk_gen.sv
verif/tb_cpl_rx.sv

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;       // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

/* verif/tb_cpl_rx.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rx_cfg.svh"

module tb_cpl_rx import rx_pkg::*; ();

    localparam int NTAG   = 1 << `RX_TAG_W;
    localparam int BUF_QW = 1 << `RX_BUF_AW;

    logic              clk;
    logic              rst;
    logic [63:0]       desc_addr;
    logic [31:0]       desc_len;
    logic              desc_valid;
    logic              desc_done;
    logic [2:0]        max_rd_req;
    logic [`RX_DW-1:0] rx_data;
    logic              rx_sof;
    logic              rx_eof;
    logic              rx_valid;
    logic              rd;
    logic [63:0]       rd_addr;
    qw_len_t           rd_qw;
    logic              rd_ack;
    tag_t              rd_tag;
    logic              wr_en;
    buf_addr_t         wr_addr;
    logic [`RX_DW-1:0] wr_data;
    buf_ptr_t          committed_prod;
    buf_ptr_t          committed_cons;
    logic              cpl_rcved;
    dw_len_t           cpl_dws;

    // host side bookkeeping
    logic [31:0] exp_lo [BUF_QW];
    logic [31:0] exp_hi [BUF_QW];
    bit          has_lo [BUF_QW];
    bit          has_hi [BUF_QW];
    bit          busy   [NTAG];
    buf_ptr_t    tb_ptr;
    buf_ptr_t    last_prod;
    buf_ptr_t    end_ptr_q [$];
    tag_t        end_tag_q [$];
    tag_t        c_tag [$];
    logic [31:0] c_addr [$];
    int          c_bdw [$];
    int          c_len [$];
    int          dws_q [$];
    logic [63:0] exp_addr;
    int          remaining;
    int          total_qw;
    int          wr_count;
    int          desc_started;
    int          desc_done_cnt;
    bit          cons_stall;
    bit          rd_seen;

    tb_clk_gen i_clk_gen (.clk(clk), .rst(rst));

    cpl_rx_top i_cpl_rx_top (
        .clk(clk), .rst(rst),
        .desc_addr(desc_addr), .desc_len(desc_len), .desc_valid(desc_valid),
        .desc_done(desc_done), .max_rd_req(max_rd_req),
        .rx_data(rx_data), .rx_sof(rx_sof), .rx_eof(rx_eof), .rx_valid(rx_valid),
        .rd(rd), .rd_addr(rd_addr), .rd_qw(rd_qw), .rd_ack(rd_ack), .rd_tag(rd_tag),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .committed_prod(committed_prod), .committed_cons(committed_cons),
        .cpl_rcved(cpl_rcved), .cpl_dws(cpl_dws)
    );

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic stop_run(input string msg);
        $display("%s (at %0t ns)", msg, $time);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic int cap_qw(input logic [2:0] m);
        case (m)
            3'd0:    return 16;
            3'd1:    return 32;
            3'd2:    return 64;
            default: return 128;
        endcase
    endfunction

    function automatic logic [31:0] byte_rev(input logic [31:0] d);
        return {d[7:0], d[15:8], d[23:16], d[31:24]};
    endfunction

    //////////////////////////////
    // host read responder
    //////////////////////////////
    task automatic accept_request();
        tag_t free_tags [$];
        tag_t t;
        int   nd;
        int   pieces;
        int   off;
        int   sz;
        for (int i = 0; i < NTAG; i++) begin
            if (!busy[i]) free_tags.push_back(tag_t'(i));
        end
        if (free_tags.size() == 0) stop_run("host has no free tag for a request");
        t = free_tags[$urandom % free_tags.size()];
        busy[t] = 1'b1;
        rd_tag  = t;
        rd_ack  = 1'b1;
        end_ptr_q.push_back(tb_ptr + buf_ptr_t'(rd_qw));
        end_tag_q.push_back(t);
        // one to three completions, odd splits allowed
        nd     = 2 * int'(rd_qw);
        pieces = 1 + $urandom % 3;
        off    = 0;
        for (int i = 0; i < pieces; i++) begin
            if (i == pieces - 1) sz = nd - off;
            else sz = 1 + $urandom % (nd - off - (pieces - 1 - i));
            c_tag.push_back(t);
            c_addr.push_back(rd_addr[31:0] + 32'(4 * off));
            c_bdw.push_back(2 * int'(tb_ptr) + off);
            c_len.push_back(sz);
            off += sz;
        end
        tb_ptr = tb_ptr + buf_ptr_t'(rd_qw);
    endtask

    initial begin : rd_responder
        int delay;
        delay = -1;
        forever begin
            next_cycle();
            rd_ack = 1'b0;
            if (rst || !rd) delay = -1;
            else if (delay < 0) delay = $urandom % 6;
            if (delay == 0) begin
                accept_request();
                delay = -1;
            end else if (delay > 0) begin
                delay--;
            end
        end
    end

    //////////////////////////////
    // completion stream
    //////////////////////////////
    task automatic drive_beat(input logic [63:0] d, input logic sof, input logic eof);
        while ($urandom % 4 == 0) begin   // idle gap
            rx_valid = 1'b0;
            next_cycle();
        end
        rx_data  = d;
        rx_sof   = sof;
        rx_eof   = eof;
        rx_valid = 1'b1;
        next_cycle();
        rx_valid = 1'b0;
        rx_sof   = 1'b0;
        rx_eof   = 1'b0;
    endtask

    // kind 0 good, 1 bad status, 2 foreign tag base, 3 not a completion
    task automatic send_frame(input tag_t t, input logic [31:0] addr, input int bdw,
                              input int n, input int kind);
        logic [6:0]  code;
        logic [2:0]  st;
        logic [4:0]  tag_hi;
        logic [31:0] d [$];
        int          q;
        code   = (kind == 3) ? 7'b000_0000 : `RX_CPLD_CODE;
        st     = (kind == 1) ? 3'b010 : `RX_SC;
        tag_hi = (kind == 2) ? 5'b00110 : `RX_TAG_BASE;
        for (int i = 0; i < n; i++) begin
            d.push_back((addr + 32'(4 * i)) ^ 32'h5a5a0000);
            if (kind == 0) begin
                q = ((bdw + i) >> 1) % BUF_QW;
                if ((bdw + i) % 2 == 1) begin
                    exp_hi[q] = byte_rev(d[i]);
                    has_hi[q] = 1'b1;
                end else begin
                    exp_lo[q] = byte_rev(d[i]);
                    has_lo[q] = 1'b1;
                end
            end
        end
        if (kind == 0) dws_q.push_back(n);
        drive_beat({1'b0, code, 14'h0, 10'(n), 16'h0, st, 13'h0}, 1'b1, 1'b0);
        drive_beat({16'h0, tag_hi, t, 8'h0, d[0]}, 1'b0, n == 1);
        for (int i = 1; i < n; i += 2) begin
            drive_beat({d[i], (i + 1 < n) ? d[i + 1] : 32'hdead_beef}, 1'b0, i + 2 >= n);
        end
    endtask

    initial begin : cpl_sender
        int          k;
        int          j;
        tag_t        t;
        logic [31:0] a;
        int          b;
        int          n;
        next_cycle();
        forever begin
            if (rst || c_tag.size() == 0) begin
                next_cycle();
            end else if ($urandom % 8 == 0) begin
                send_frame(tag_t'($urandom), $urandom, 0, 1 + $urandom % 6, 1 + $urandom % 3);
            end else begin
                // random tag, oldest chunk of that tag
                k = $urandom % c_tag.size();
                j = 0;
                while (c_tag[j] != c_tag[k]) j++;
                t = c_tag[j];
                a = c_addr[j];
                b = c_bdw[j];
                n = c_len[j];
                c_tag.delete(j);
                c_addr.delete(j);
                c_bdw.delete(j);
                c_len.delete(j);
                send_frame(t, a, b, n, 0);
            end
        end
    end

    initial begin : consumer
        int diff;
        forever begin
            next_cycle();
            if (!rst && !cons_stall && $urandom % 4 == 0) begin
                diff = int'(buf_ptr_t'(committed_prod - committed_cons));
                if (diff > 0) committed_cons = committed_cons + buf_ptr_t'(1 + $urandom % diff);
            end
        end
    end

    //////////////////////////////
    // output checks
    //////////////////////////////
    always @(posedge clk) begin
        if (!rst && rd && !rd_seen) begin
            assert (rd_qw != 0 && int'(rd_qw) <= cap_qw(max_rd_req) && int'(rd_qw) <= remaining)
                else report_error($sformatf("request size %0d out of range", rd_qw));
            assert (rd_addr == exp_addr)
                else report_error($sformatf("rd_addr %h, expected %h", rd_addr, exp_addr));
            assert (end_ptr_q.size() < NTAG)
                else report_error("rd raised with all tags outstanding");
            assert (int'(buf_ptr_t'(tb_ptr - committed_cons)) + int'(rd_qw) <= BUF_QW)
                else report_error("rd raised without buffer space");
            exp_addr  = exp_addr + 64'(8 * int'(rd_qw));
            remaining = remaining - int'(rd_qw);
        end
        rd_seen = rd && !rst;
    end

    always @(posedge clk) begin
        if (!rst && wr_en) begin
            assert (has_lo[wr_addr] && has_hi[wr_addr])
                else report_error($sformatf("write to %0d with no data sent", wr_addr));
            assert (wr_data == {exp_hi[wr_addr], exp_lo[wr_addr]})
                else report_error($sformatf("wr_data %h at %0d, expected %h", wr_data, wr_addr,
                                            {exp_hi[wr_addr], exp_lo[wr_addr]}));
            has_lo[wr_addr] = 1'b0;
            has_hi[wr_addr] = 1'b0;
            wr_count++;
        end
        if (!rst && committed_prod != last_prod) begin
            assert (end_ptr_q.size() > 0 && committed_prod == end_ptr_q[0])
                else report_error($sformatf("committed_prod %0d not the next request end",
                                            committed_prod));
            assert (int'(buf_ptr_t'(committed_prod - last_prod)) <= BUF_QW)
                else report_error("committed_prod moved backwards");
            busy[end_tag_q[0]] = 1'b0;       // tag retired
            void'(end_ptr_q.pop_front());
            void'(end_tag_q.pop_front());
            last_prod = committed_prod;
        end
        if (!rst && cpl_rcved) begin
            assert (dws_q.size() > 0 && int'(cpl_dws) == dws_q[0])
                else report_error($sformatf("cpl_rcved with cpl_dws %0d unexpected", cpl_dws));
            if (dws_q.size() > 0) void'(dws_q.pop_front());
        end
        if (!rst && desc_done) begin
            desc_done_cnt++;
            assert (remaining == 0 && desc_done_cnt <= desc_started)
                else report_error("desc_done before the descriptor was fully requested");
        end
    end

    //////////////////////////////
    // descriptor runs
    //////////////////////////////
    task automatic run_desc(input logic [63:0] addr, input int len, input logic [2:0] mx,
                            input bit stall);
        int cnt;
        max_rd_req = mx;
        repeat (4) next_cycle();
        exp_addr   = addr;
        remaining  = len;
        total_qw  += len;
        desc_started++;
        desc_addr  = addr;
        desc_len   = 32'(len);
        desc_valid = 1'b1;
        cons_stall = stall;
        next_cycle();
        desc_valid = 1'b0;
        if (stall) repeat (600) next_cycle();   // buffer fills, requests must hold
        cons_stall = 1'b0;
        cnt = 0;
        while (desc_done_cnt < desc_started) begin
            next_cycle();
            cnt++;
            if (cnt > 20000) stop_run("timeout waiting for desc_done");
        end
        cnt = 0;
        while (end_ptr_q.size() > 0 || c_tag.size() > 0 || dws_q.size() > 0) begin
            next_cycle();
            cnt++;
            if (cnt > 20000) stop_run("timeout waiting for all requests to commit");
        end
    endtask

    initial begin : main
        int cnt;
        void'($urandom(32'h178e));
        desc_addr      = '0;
        desc_len       = '0;
        desc_valid     = 1'b0;
        max_rd_req     = 3'd0;
        rx_data        = '0;
        rx_sof         = 1'b0;
        rx_eof         = 1'b0;
        rx_valid       = 1'b0;
        rd_ack         = 1'b0;
        rd_tag         = '0;
        committed_cons = '0;
        tb_ptr         = '0;
        last_prod      = '0;
        total_qw       = 0;
        wr_count       = 0;
        desc_started   = 0;
        desc_done_cnt  = 0;
        cons_stall     = 1'b0;
        rd_seen        = 1'b0;
        for (int i = 0; i < NTAG; i++) busy[i] = 1'b0;
        for (int i = 0; i < BUF_QW; i++) begin
            has_lo[i] = 1'b0;
            has_hi[i] = 1'b0;
        end
        cnt = 0;
        while (rst) begin
            next_cycle();
            cnt++;
            if (cnt > 20) stop_run("reset was never released");
        end
        assert (!rd && !wr_en && !desc_done && !cpl_rcved && committed_prod == '0)
            else report_error("outputs not idle after reset");

        // many small requests, tags run out before data comes back
        run_desc(64'h0000_0001_0000_0040, 320, 3'd0, 1'b0);
        run_desc(64'h0000_0000_2000_0100, 100, 3'd1, 1'b0);
        run_desc(64'h0000_0000_0300_0008, 300, 3'd2, 1'b0);
        run_desc(64'h0000_0002_0040_0000, 700, 3'd3, 1'b1);
        run_desc(64'h0000_0000_0000_1000, 250, 3'd5, 1'b0);

        repeat (10) next_cycle();
        assert (wr_count == total_qw)
            else report_error($sformatf("%0d writes, expected %0d", wr_count, total_qw));
        assert (committed_prod == buf_ptr_t'(total_qw))
            else report_error($sformatf("final committed_prod %0d", committed_prod));
        assert (desc_done_cnt == desc_started)
            else report_error("desc_done count differs from descriptor count");
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire
